//--- src/isa_pkg.sv
package isa_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // return address of jal
    localparam reg_idx_t LINK_REG = 5'd31;

    // primary opcodes in inst[31:26]
    typedef enum logic [OPCODE_W-1:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    // function field under SPECIAL
    typedef enum logic [FUNCT_W-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLLV = 6'h04,
        FN_SRLV = 6'h06,
        FN_SRAV = 6'h07,
        FN_JR   = 6'h08,
        FN_JALR = 6'h09,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    // rt field under REGIMM
    typedef enum logic [REG_ADDR_W-1:0] {
        RI_BLTZ = 5'h00,
        RI_BGEZ = 5'h01
    } regimm_e;

endpackage

//--- src/pipe_pkg.sv
package pipe_pkg;

    typedef struct packed {
        logic if_stall;
        logic id_stall;
    } stall_t;

    typedef struct packed {
        logic          valid;
        isa_pkg::word_t pc;
    } if_id_t;

    // bypass from MEM
    typedef struct packed {
        logic              we;
        isa_pkg::reg_idx_t waddr;
        isa_pkg::word_t    wdata;
    } fwd_t;

    // EX bypass whose is_load marks data not ready yet
    typedef struct packed {
        logic              we;
        isa_pkg::reg_idx_t waddr;
        isa_pkg::word_t    wdata;
        logic              is_load;
    } ex_fwd_t;

    typedef struct packed {
        logic              we;
        isa_pkg::reg_idx_t waddr;
        isa_pkg::word_t    wdata;
    } wb_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC1_RS, SRC1_PC, SRC1_SA
    } src1_e;

    typedef enum logic [1:0] {
        SRC2_RT, SRC2_IMM_SEXT, SRC2_IMM_ZEXT, SRC2_EIGHT
    } src2_e;

    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::word_t    inst;
        alu_op_e           alu_op;
        src1_e             src1;
        src2_e             src2;
        logic              mem_en;
        logic              mem_we;
        logic              rf_we;
        isa_pkg::reg_idx_t rf_waddr;
        isa_pkg::word_t    rs_val;
        isa_pkg::word_t    rt_val;
    } id_ex_t;

    typedef struct packed {
        logic           taken;
        isa_pkg::word_t target;
    } br_t;

endpackage

//--- src/if_id_reg.sv
`timescale 1ns/1ps

module if_id_reg (
    input  logic             clk,
    input  logic             rst,
    input  pipe_pkg::stall_t stall,
    input  pipe_pkg::if_id_t if_id_in,
    input  isa_pkg::word_t   inst_rdata,
    output pipe_pkg::if_id_t if_id_out,
    output isa_pkg::word_t   inst
);
    import isa_pkg::*;

    word_t hold_inst;
    logic  hold_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id_out  <= '0;
            hold_valid <= 1'b0;
        end else if (stall.id_stall) begin
            // first stalled cycle keeps the fetched word
            if (!hold_valid) begin
                hold_inst  <= inst_rdata;
                hold_valid <= 1'b1;
            end
        end else if (stall.if_stall) begin
            if_id_out  <= '0;
            hold_valid <= 1'b0;
        end else begin
            if_id_out  <= if_id_in;
            hold_valid <= 1'b0;
        end
    end

    assign inst = hold_valid ? hold_inst : inst_rdata;

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        if_id_out.valid |-> (if_id_out.pc[1:0] == 2'b00));

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  isa_pkg::reg_idx_t raddr1,
    input  isa_pkg::reg_idx_t raddr2,
    input  pipe_pkg::ex_fwd_t ex_fwd,
    input  pipe_pkg::fwd_t    mem_fwd,
    input  pipe_pkg::wb_t     wb,
    output isa_pkg::word_t    rdata1,
    output isa_pkg::word_t    rdata2
);
    import isa_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.waddr != '0)) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // youngest producer wins
    function automatic word_t read_port(input reg_idx_t addr, input word_t stored);
        word_t val;
        if (addr == '0) begin
            val = '0;
        end else if (ex_fwd.we && (ex_fwd.waddr == addr)) begin
            val = ex_fwd.wdata;
        end else if (mem_fwd.we && (mem_fwd.waddr == addr)) begin
            val = mem_fwd.wdata;
        end else if (wb.we && (wb.waddr == addr)) begin
            val = wb.wdata;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1, regs[raddr1]);
        rdata2 = read_port(raddr2, regs[raddr2]);
    end

    a_zero_reg: assert property (@(posedge clk) disable iff (rst)
        (wb.we && (wb.waddr == '0)) |=> (regs[0] == '0));

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  logic              valid,
    input  isa_pkg::word_t    pc,
    input  isa_pkg::word_t    inst,
    input  isa_pkg::word_t    rs_val,
    input  isa_pkg::word_t    rt_val,
    output isa_pkg::reg_idx_t rs,
    output isa_pkg::reg_idx_t rt,
    output pipe_pkg::id_ex_t  ctrl
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_e  opcode;
    funct_e   funct;
    reg_idx_t rd;
    reg_idx_t sa;
    alu_op_e  alu_op;
    src1_e    src1;
    src2_e    src2;
    logic     is_load;
    logic     is_store;
    logic     wr_rd;
    logic     wr_rt;
    logic     wr_link;

    assign opcode = opcode_e'(inst[31:26]);
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign sa     = inst[10:6];
    assign funct  = funct_e'(inst[5:0]);

    always_comb begin
        alu_op   = ALU_ADD;
        src1     = SRC1_RS;
        src2     = SRC2_RT;
        is_load  = 1'b0;
        is_store = 1'b0;
        wr_rd    = 1'b0;
        wr_rt    = 1'b0;
        wr_link  = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL, FN_SRL, FN_SRA: begin
                        wr_rd  = (rs == '0);
                        src1   = SRC1_SA;
                        alu_op = (funct == FN_SLL) ? ALU_SLL :
                                 (funct == FN_SRL) ? ALU_SRL : ALU_SRA;
                    end
                    FN_SLLV: begin wr_rd = (sa == '0); alu_op = ALU_SLL;  end
                    FN_SRLV: begin wr_rd = (sa == '0); alu_op = ALU_SRL;  end
                    FN_SRAV: begin wr_rd = (sa == '0); alu_op = ALU_SRA;  end
                    FN_ADDU: begin wr_rd = (sa == '0); alu_op = ALU_ADD;  end
                    FN_SUBU: begin wr_rd = (sa == '0); alu_op = ALU_SUB;  end
                    FN_AND:  begin wr_rd = (sa == '0); alu_op = ALU_AND;  end
                    FN_OR:   begin wr_rd = (sa == '0); alu_op = ALU_OR;   end
                    FN_XOR:  begin wr_rd = (sa == '0); alu_op = ALU_XOR;  end
                    FN_NOR:  begin wr_rd = (sa == '0); alu_op = ALU_NOR;  end
                    FN_SLT:  begin wr_rd = (sa == '0); alu_op = ALU_SLT;  end
                    FN_SLTU: begin wr_rd = (sa == '0); alu_op = ALU_SLTU; end
                    FN_JALR: begin
                        // link value pc+8 computed in EX
                        wr_rd = (rt == '0) && (sa == '0);
                        src1  = SRC1_PC;
                        src2  = SRC2_EIGHT;
                    end
                    default: ;
                endcase
            end
            OP_JAL: begin
                wr_link = 1'b1;
                src1    = SRC1_PC;
                src2    = SRC2_EIGHT;
            end
            OP_ADDIU: begin wr_rt = 1'b1; src2 = SRC2_IMM_SEXT; end
            OP_SLTI:  begin wr_rt = 1'b1; src2 = SRC2_IMM_SEXT; alu_op = ALU_SLT;  end
            OP_SLTIU: begin wr_rt = 1'b1; src2 = SRC2_IMM_SEXT; alu_op = ALU_SLTU; end
            OP_ANDI:  begin wr_rt = 1'b1; src2 = SRC2_IMM_ZEXT; alu_op = ALU_AND;  end
            OP_ORI:   begin wr_rt = 1'b1; src2 = SRC2_IMM_ZEXT; alu_op = ALU_OR;   end
            OP_XORI:  begin wr_rt = 1'b1; src2 = SRC2_IMM_ZEXT; alu_op = ALU_XOR;  end
            OP_LUI:   begin wr_rt = (rs == '0); src2 = SRC2_IMM_ZEXT; alu_op = ALU_LUI; end
            OP_LW:    begin wr_rt = 1'b1; is_load = 1'b1; src2 = SRC2_IMM_SEXT; end
            OP_SW:    begin is_store = 1'b1; src2 = SRC2_IMM_SEXT; end
            // branches and plain jumps are resolved in branch_unit
            default: ;
        endcase
    end

    always_comb begin
        ctrl.valid    = valid;
        ctrl.pc       = pc;
        ctrl.inst     = inst;
        ctrl.alu_op   = alu_op;
        ctrl.src1     = src1;
        ctrl.src2     = src2;
        ctrl.mem_en   = valid && (is_load || is_store);
        ctrl.mem_we   = valid && is_store;
        ctrl.rf_we    = valid && (wr_rd || wr_rt || wr_link);
        ctrl.rf_waddr = wr_link ? LINK_REG : wr_rt ? rt : wr_rd ? rd : '0;
        ctrl.rs_val   = rs_val;
        ctrl.rt_val   = rt_val;
    end

    // no kept instruction both stores and writes back
    always_comb begin
        a_we_exclusive: assert (!(ctrl.rf_we && ctrl.mem_we))
            else $error("rf_we and mem_we both set for inst %h", inst);
    end

endmodule

//--- src/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic           valid,
    input  isa_pkg::word_t pc,
    input  isa_pkg::word_t inst,
    input  isa_pkg::word_t rs_val,
    input  isa_pkg::word_t rt_val,
    output pipe_pkg::br_t  br
);
    import isa_pkg::*;

    opcode_e opcode;
    word_t   pc_plus_4;
    word_t   br_target;
    word_t   j_target;
    logic    rs_zero;
    logic    is_jr;
    logic    is_jalr;
    logic    cond_taken;
    logic    is_jump_imm;

    assign opcode    = opcode_e'(inst[31:26]);
    assign pc_plus_4 = pc + 32'd4;
    assign br_target = pc_plus_4 + {{14{inst[15]}}, inst[15:0], 2'b00};
    // stays in the 256 MB region of the delay slot
    assign j_target  = {pc_plus_4[31:28], inst[25:0], 2'b00};
    assign rs_zero   = (rs_val == '0);

    assign is_jr   = (opcode == OP_SPECIAL) && (funct_e'(inst[5:0]) == FN_JR)
                     && (inst[20:6] == '0);
    assign is_jalr = (opcode == OP_SPECIAL) && (funct_e'(inst[5:0]) == FN_JALR)
                     && (inst[20:16] == '0) && (inst[10:6] == '0);
    assign is_jump_imm = (opcode == OP_J) || (opcode == OP_JAL);

    always_comb begin
        cond_taken = 1'b0;
        case (opcode)
            OP_BEQ:  cond_taken = (rs_val == rt_val);
            OP_BNE:  cond_taken = (rs_val != rt_val);
            OP_BGTZ: cond_taken = (inst[20:16] == '0) && !rs_val[31] && !rs_zero;
            OP_BLEZ: cond_taken = (inst[20:16] == '0) && (rs_val[31] || rs_zero);
            OP_REGIMM: begin
                if (regimm_e'(inst[20:16]) == RI_BLTZ) begin
                    cond_taken = rs_val[31];
                end else if (regimm_e'(inst[20:16]) == RI_BGEZ) begin
                    cond_taken = !rs_val[31];
                end
            end
            default: ;
        endcase
    end

    assign br.taken  = valid && (cond_taken || is_jump_imm || is_jr || is_jalr);
    assign br.target = (is_jr || is_jalr) ? rs_val :
                       is_jump_imm        ? j_target : br_target;

endmodule

//--- src/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic              clk,
    input  logic              rst,
    input  pipe_pkg::stall_t  stall,
    input  pipe_pkg::if_id_t  if_id,
    input  isa_pkg::word_t    inst_rdata,
    input  pipe_pkg::ex_fwd_t ex_fwd,
    input  pipe_pkg::fwd_t    mem_fwd,
    input  pipe_pkg::wb_t     wb,
    output logic              stallreq,
    output pipe_pkg::id_ex_t  id_ex,
    output pipe_pkg::br_t     br
);
    import isa_pkg::*;
    import pipe_pkg::*;

    if_id_t   if_id_q;
    word_t    inst;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    rs_val;
    word_t    rt_val;

    if_id_reg i_if_id_reg (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .if_id_in   (if_id),
        .inst_rdata (inst_rdata),
        .if_id_out  (if_id_q),
        .inst       (inst)
    );

    reg_file i_reg_file (
        .clk     (clk),
        .rst     (rst),
        .raddr1  (rs),
        .raddr2  (rt),
        .ex_fwd  (ex_fwd),
        .mem_fwd (mem_fwd),
        .wb      (wb),
        .rdata1  (rs_val),
        .rdata2  (rt_val)
    );

    inst_decoder i_inst_decoder (
        .valid  (if_id_q.valid),
        .pc     (if_id_q.pc),
        .inst   (inst),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .rs     (rs),
        .rt     (rt),
        .ctrl   (id_ex)
    );

    branch_unit i_branch_unit (
        .valid  (if_id_q.valid),
        .pc     (if_id_q.pc),
        .inst   (inst),
        .rs_val (rs_val),
        .rt_val (rt_val),
        .br     (br)
    );

    // a load in EX feeding this instruction has its data only in MEM
    assign stallreq = if_id_q.valid && ex_fwd.is_load && (ex_fwd.waddr != '0)
                      && ((ex_fwd.waddr == rs) || (ex_fwd.waddr == rt));

endmodule

//--- verif/tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int MAX_LINES  = 64;
    localparam int NUM_FIELDS = 27;

    logic      clk = 1'b0;
    logic      rst;
    stall_t    stall;
    if_id_t    if_id;
    word_t     inst_rdata;
    ex_fwd_t   ex_fwd;
    fwd_t      mem_fwd;
    wb_t       wb;
    logic      stallreq;
    id_ex_t    id_ex;
    br_t       br;

    // trace contents per pipeline cycle
    string       name_a  [MAX_LINES];
    stall_t      stall_a [MAX_LINES];
    if_id_t      if_id_a [MAX_LINES];
    word_t       inst_a  [MAX_LINES];
    ex_fwd_t     ex_a    [MAX_LINES];
    fwd_t        mem_a   [MAX_LINES];
    wb_t         wb_a    [MAX_LINES];
    logic [31:0] exp_a   [MAX_LINES][13];

    int   num_lines = 0;
    int   errors    = 0;
    logic trace_ok  = 1'b0;

    // latched pc and instruction word predicted from the stall vector
    word_t exp_pc   = '0;
    word_t exp_inst = '0;
    logic  holding  = 1'b0;

    id_stage i_id_stage (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .if_id      (if_id),
        .inst_rdata (inst_rdata),
        .ex_fwd     (ex_fwd),
        .mem_fwd    (mem_fwd),
        .wb         (wb),
        .stallreq   (stallreq),
        .id_ex      (id_ex),
        .br         (br)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_trace();
        int             fd;
        int             cnt;
        string          line;
        logic [8*16-1:0] name_buf;
        logic [31:0]    v [NUM_FIELDS];
        fd = $fopen("verif/id_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open trace file verif/id_trace.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                cnt = $sscanf(line, "%s%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
                              name_buf, v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                              v[7], v[8], v[9], v[10], v[11], v[12], v[13], v[14],
                              v[15], v[16], v[17], v[18], v[19], v[20], v[21], v[22],
                              v[23], v[24], v[25], v[26]);
                if (cnt != NUM_FIELDS + 1 || num_lines == MAX_LINES) begin
                    $display("malformed or surplus trace line: %0s", line);
                    errors++;
                    continue;
                end
                name_a[num_lines]  = $sformatf("%0s", name_buf);
                stall_a[num_lines] = stall_t'(v[0][1:0]);
                if_id_a[num_lines] = '{valid: v[1][0], pc: v[2]};
                inst_a[num_lines]  = v[3];
                ex_a[num_lines]    = '{we: v[4][0], waddr: v[5][4:0], wdata: v[6],
                                       is_load: v[7][0]};
                mem_a[num_lines]   = '{we: v[8][0], waddr: v[9][4:0], wdata: v[10]};
                wb_a[num_lines]    = '{we: v[11][0], waddr: v[12][4:0], wdata: v[13]};
                for (int f = 0; f < 13; f++) begin
                    exp_a[num_lines][f] = v[14 + f];
                end
                num_lines++;
            end
            $fclose(fd);
            trace_ok = (num_lines > 0) && (errors == 0);
        end
    endtask

    // id_stall holds pc and the word fetched before it, if_stall inserts a bubble
    task automatic predict_latch(input int i);
        if (stall_a[i].id_stall) begin
            if (!holding) begin
                exp_inst = (i > 0) ? inst_a[i-1] : '0;
                holding  = 1'b1;
            end
        end else begin
            holding  = 1'b0;
            exp_inst = inst_a[i];
            exp_pc   = stall_a[i].if_stall ? '0 : if_id_a[i].pc;
        end
    endtask

    task automatic check_field(input string test, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("MISMATCH %0s %0s expected %h actual %h", test, field, exp, act);
            errors++;
        end
    endtask

    task automatic compare_line(input int i);
        check_field(name_a[i], "stallreq", exp_a[i][0],  32'(stallreq));
        check_field(name_a[i], "valid",    exp_a[i][1],  32'(id_ex.valid));
        check_field(name_a[i], "alu_op",   exp_a[i][2],  32'(id_ex.alu_op));
        check_field(name_a[i], "src1",     exp_a[i][3],  32'(id_ex.src1));
        check_field(name_a[i], "src2",     exp_a[i][4],  32'(id_ex.src2));
        check_field(name_a[i], "rf_we",    exp_a[i][5],  32'(id_ex.rf_we));
        check_field(name_a[i], "rf_waddr", exp_a[i][6],  32'(id_ex.rf_waddr));
        check_field(name_a[i], "mem_en",   exp_a[i][7],  32'(id_ex.mem_en));
        check_field(name_a[i], "mem_we",   exp_a[i][8],  32'(id_ex.mem_we));
        check_field(name_a[i], "rs_val",   exp_a[i][9],  id_ex.rs_val);
        check_field(name_a[i], "rt_val",   exp_a[i][10], id_ex.rt_val);
        check_field(name_a[i], "br_taken", exp_a[i][11], 32'(br.taken));
        check_field(name_a[i], "br_target", exp_a[i][12], br.target);
        if (exp_a[i][1][0]) begin
            check_field(name_a[i], "pc",   exp_pc,   id_ex.pc);
            check_field(name_a[i], "inst", exp_inst, id_ex.inst);
        end
    endtask

    initial begin
        rst        = 1'b1;
        stall      = '0;
        if_id      = '0;
        inst_rdata = '0;
        ex_fwd     = '0;
        mem_fwd    = '0;
        wb         = '0;
        load_trace();
        if (!trace_ok) begin
            $display("trace could not be loaded, nothing was run");
            $display("SIMULATION FAILED");
            $finish;
        end else begin
            repeat (4) @(posedge clk);
            rst <= 1'b0;
            // line k enters IF/ID while line k-1 is decoded
            for (int k = 0; k <= num_lines; k++) begin
                if (k > 0) begin
                    @(posedge clk);
                end
                if (k < num_lines) begin
                    stall <= stall_a[k];
                    if_id <= if_id_a[k];
                end else begin
                    stall <= '0;
                    if_id <= '0;
                end
                if (k > 0) begin
                    inst_rdata <= inst_a[k-1];
                    ex_fwd     <= ex_a[k-1];
                    mem_fwd    <= mem_a[k-1];
                    wb         <= wb_a[k-1];
                    @(negedge clk);
                    predict_latch(k - 1);
                    compare_line(k - 1);
                end
            end
            $display("errors: %0d over %0d trace lines", errors, num_lines);
            if (errors == 0) begin
                $display("SIMULATION PASSED");
            end else begin
                $display("SIMULATION FAILED");
            end
            $finish;
        end
    end

    // watchdog
    initial begin
        wait (trace_ok);
        #((num_lines + 10) * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", num_lines + 10);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- verif/id_trace.txt
# name stall valid pc inst | ex: we addr data load | mem: we addr data | wb: we addr data
# expect: stallreq valid alu_op src1 src2 rf_we rf_waddr mem_en mem_we rs_val rt_val taken target
wr_r1 0 1 00400000 00221821 0 00 00000000 0 0 00 00000000 1 01 11111111 0 1 0 0 0 1 03 0 0 11111111 00000000 0 00406088
wr_r2 0 1 00400004 00221821 0 00 00000000 0 0 00 00000000 1 02 22222222 0 1 0 0 0 1 03 0 0 11111111 22222222 0 0040608c
wr_r0 0 1 00400008 00012021 0 00 00000000 0 0 00 00000000 1 00 deadbeef 0 1 0 0 0 1 04 0 0 00000000 11111111 0 00408090
rd_r0 0 1 0040000c 00402821 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 0 1 05 0 0 22222222 00000000 0 0040a094
byp_all 0 1 00400010 00223021 1 01 aaaaaaaa 0 1 01 bbbbbbbb 1 01 cccccccc 0 1 0 0 0 1 06 0 0 aaaaaaaa 22222222 0 0040c098
byp_mem 0 1 00400014 00223021 0 00 00000000 0 1 01 bbbbbbbb 1 01 dddddddd 0 1 0 0 0 1 06 0 0 bbbbbbbb 22222222 0 0040c09c
byp_none 0 1 00400018 00223021 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 0 1 06 0 0 dddddddd 22222222 0 0040c0a0
dec_ori 0 1 0040001c 342700f0 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 6 0 2 1 07 0 0 dddddddd 00000000 0 004003e0
dec_lui 0 1 00400020 3c081234 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 b 0 2 1 08 0 0 00000000 00000000 0 004048f4
dec_sll 0 1 00400024 00024900 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 8 2 0 1 09 0 0 00000000 22222222 0 00412428
dec_slt 0 1 00400028 0022502a 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 2 0 0 1 0a 0 0 dddddddd 22222222 0 004140d4
dec_lw 0 1 0040002c 8c2b0008 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 1 1 0b 1 0 dddddddd 00000000 0 00400050
dec_sw 0 1 00400030 ac22fffc 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 1 0 00 1 1 dddddddd 22222222 0 00400024
dec_undef 0 1 00400034 fc000000 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 0 0 00 0 0 00000000 00000000 0 00400038
beq_t 0 1 00400038 10420004 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 0 0 00 0 0 22222222 22222222 1 0040004c
beq_n 0 1 0040003c 10220004 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 0 0 00 0 0 dddddddd 22222222 0 00400050
bne_t 0 1 00400040 1422fffe 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 0 0 00 0 0 dddddddd 22222222 1 0040003c
bne_n 0 1 00400044 14420001 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 0 0 00 0 0 22222222 22222222 0 0040004c
bgtz_neg 0 1 00400048 1c200002 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 0 0 00 0 0 dddddddd 00000000 0 00400054
bltz_neg 0 1 0040004c 04200003 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 0 0 00 0 0 dddddddd 00000000 1 0040005c
j_region 0 1 00400050 08100100 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 0 0 00 0 0 00000000 00000000 1 00400400
jal_link 0 1 00400054 0c100200 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 1 3 1 1f 0 0 00000000 00000000 1 00400800
jr_byp 0 1 00400058 00600008 1 03 00401000 0 0 00 00000000 0 00 00000000 0 1 0 0 0 0 00 0 0 00401000 00000000 1 00401000
if_bubble 2 1 0040005c 00000000 0 00 00000000 0 0 00 00000000 0 00 00000000 0 0 8 2 0 0 00 0 0 00000000 00000000 0 00000004
pre_hold 0 1 0040005c 8c4c0000 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 1 1 0c 1 0 22222222 00000000 0 00400060
id_hold 1 1 00400060 fc000000 0 00 00000000 0 0 00 00000000 0 00 00000000 0 1 0 0 1 1 0c 1 0 22222222 00000000 0 00400060
ld_use 0 1 00400060 00416821 1 01 0badf00d 1 0 00 00000000 0 00 00000000 1 1 0 0 0 1 0d 0 0 22222222 0badf00d 0 0041a0e8
ld_r0 0 1 00400064 00416821 1 00 12345678 1 0 00 00000000 0 00 00000000 0 1 0 0 0 1 0d 0 0 22222222 dddddddd 0 0041a0ec
no_load 0 1 00400068 00416821 1 02 55555555 0 0 00 00000000 0 00 00000000 0 1 0 0 0 1 0d 0 0 55555555 dddddddd 0 0041a0f0

//--- sim.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/if_id_reg.sv
src/reg_file.sv
src/inst_decoder.sv
src/branch_unit.sv
src/id_stage.sv
verif/tb_id_stage.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_id_stage > compile.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see compile.log"
    exit 1
fi

./obj_dir/Vtb_id_stage > sim.log 2>&1
if [ $? -ne 0 ]; then
    echo "simulation exited with an error, see sim.log"
    exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
    echo "test failed, see sim.log"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
echo "test passed"
exit 0
